//--- list.f
rtl/icache_pkg.sv
rtl/icache_refill_if.sv
rtl/icache_fsm.sv
rtl/refill_counter.sv
rtl/refill_buf.sv
rtl/tagv_mem.sv
rtl/data_mem.sv
rtl/lru_sel.sv
rtl/icache.sv
verification/icache_props.sv
verification/icache_tb.sv

//--- verification/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam logic [31:0] word_key          = 32'h5a5a_0000;  // bus data pattern
    localparam int          num_random        = 40;
    localparam int          num_requests      = 21 + num_random;
    localparam int          worst_miss_cycles = 80;             // r_rdy delay plus gapped burst
    localparam int          timeout_ns        = (num_requests * worst_miss_cycles + 100) * 8;

    logic        clk;
    logic        rst;
    logic        valid;
    logic [31:0] pc_in;
    logic [31:0] cookie_in;
    logic        data_valid;
    logic [63:0] r_data_cpu;
    logic [31:0] pc_out;
    logic [31:0] cookie_out;
    logic        cache_ready;
    logic        r_req;
    logic        r_data_ready;
    logic [31:0] r_addr;
    logic        r_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] r_data_axi;
    logic [6:0]  exception;

    integer      seed = 32'ha4b0_5d4e;
    int          cycle;
    int          errors;
    int          checks;
    string       test_name;
    logic [31:0] cookie_ctr;
    logic [31:0] rand_pc [num_random];
    logic        rand_gap [num_random];
    int          plru_tags [11] = '{1, 2, 3, 4, 1, 5, 2, 1, 3, 4, 5};

    logic [31:0] req_pc_q [$];                  // accepted fetches, oldest first
    logic [31:0] req_cookie_q [$];
    int          req_cycle_q [$];
    logic [31:0] bus_addr_q [$];                // burst addresses seen on r_req

    // reference cache state
    logic [19:0] m_tag [64][4];
    bit          m_valid [64][4];
    bit          root_hi [64];                  // victim lies in ways 2/3
    bit          leaf_lo [64];                  // victim is way 1 rather than 0
    bit          leaf_hi [64];                  // victim is way 3 rather than 2

    icache UUT (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .pc_in        (pc_in),
        .cookie_in    (cookie_in),
        .data_valid   (data_valid),
        .r_data_cpu   (r_data_cpu),
        .pc_out       (pc_out),
        .cookie_out   (cookie_out),
        .cache_ready  (cache_ready),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .r_addr       (r_addr),
        .r_rdy        (r_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .r_data_axi   (r_data_axi),
        .exception    (exception)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected {exception, doubleword} for a fetch address
    function automatic logic [70:0] ref_result(input logic [31:0] pc);
        logic [31:0] base;
        logic [6:0]  exc;
        base = {pc[31:3], 3'b000};
        exc  = (pc[1:0] != 2'b00) ? {1'b1, 6'd8} : 7'd0;  // valid bit plus adef code 8
        return {exc, (base + 32'd4) ^ word_key, base ^ word_key};
    endfunction

    function automatic int model_find(input int set, input logic [19:0] tag);
        int found;
        found = -1;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                found = w;
            end
        end
        return found;
    endfunction

    function automatic int model_victim(input int set);
        int victim;
        if (root_hi[set]) begin
            victim = leaf_hi[set] ? 3 : 2;
        end else begin
            victim = leaf_lo[set] ? 1 : 0;
        end
        for (int w = 3; w >= 0; w--) begin
            if (!m_valid[set][w]) begin
                victim = w;                     // lowest empty way wins
            end
        end
        return victim;
    endfunction

    function automatic void model_touch(input int set, input int way);
        root_hi[set] = (way < 2);
        if (way < 2) begin
            leaf_lo[set] = (way == 0);
        end else begin
            leaf_hi[set] = (way == 2);
        end
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", what, expected, actual);
        end
    endtask

    task automatic check_response();
        logic [31:0] pc;
        logic [31:0] cookie;
        logic [70:0] exp;
        int          accepted;
        int          set;
        int          way;
        pc       = req_pc_q.pop_front();
        cookie   = req_cookie_q.pop_front();
        accepted = req_cycle_q.pop_front();
        exp      = ref_result(pc);
        set      = pc[11:6];
        way      = model_find(set, pc[31:12]);
        check({test_name, " bursts"}, (way < 0) ? 1 : 0, bus_addr_q.size());
        if (way < 0) begin
            if (bus_addr_q.size() != 0) begin
                check({test_name, " r_addr"}, {pc[31:6], 6'b0}, bus_addr_q.pop_front());
            end
            way                = model_victim(set);
            m_tag[set][way]    = pc[31:12];
            m_valid[set][way]  = 1'b1;
        end else begin
            check({test_name, " hit latency"}, 1, cycle - accepted);
            check({test_name, " hit ready"}, 1, cache_ready);   // next fetch taken at once
        end
        model_touch(set, way);
        check({test_name, " dword"}, exp[63:0], r_data_cpu);
        check({test_name, " pc_out"}, pc, pc_out);
        check({test_name, " cookie_out"}, cookie, cookie_out);
        check({test_name, " exception"}, exp[70:64], exception);
    endtask

    // sampled at the rising edge, inputs settle on the falling edge
    always @(posedge clk) begin : compare
        if (!rst) begin
            cycle++;
            if (r_req && r_rdy) begin
                bus_addr_q.push_back(r_addr);
            end
            if (ret_valid || data_valid) begin
                check({test_name, " r_data_ready"}, ret_valid, r_data_ready);
            end
            if (data_valid) begin
                if (req_pc_q.size() == 0) begin
                    errors++;
                    $display("data_valid raised with no fetch pending in %s", test_name);
                end else begin
                    check_response();
                end
            end
            if (valid && cache_ready) begin
                req_pc_q.push_back(pc_in);
                req_cookie_q.push_back(cookie_in);
                req_cycle_q.push_back(cycle);
            end
        end
    end

    // memory slave, random r_rdy delay and ret_valid gaps
    initial begin : bus_model
        int          delay;
        int          gap;
        logic [31:0] base;
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_axi = 32'd0;
        forever begin
            @(negedge clk);
            if (r_req) begin
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                base  = r_addr;
                r_rdy = 1'b1;
                @(negedge clk);
                r_rdy = 1'b0;
                for (int i = 0; i < 16; i++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    ret_valid  = 1'b1;
                    ret_last   = (i == 15);
                    r_data_axi = (base + 32'(4 * i)) ^ word_key;
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    // holds valid until the cache takes the fetch
    task automatic fetch(input logic [31:0] pc);
        @(negedge clk);
        valid      = 1'b1;
        pc_in      = pc;
        cookie_in  = cookie_ctr;
        cookie_ctr = cookie_ctr + 32'd1;
        do @(posedge clk); while (!cache_ready);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (req_pc_q.size() != 0) @(posedge clk);
    endtask

    initial begin : stimulus
        for (int i = 0; i < num_random; i++) begin
            rand_pc[i]  = $random(seed) & 32'h0000_70ff;   // 8 tags, 4 sets, any offset
            rand_gap[i] = $random(seed) & 1;
        end
        valid      = 1'b0;
        pc_in      = 32'd0;
        cookie_in  = 32'd0;
        cookie_ctr = 32'hc000_0000;
        rst        = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "first_miss";
        fetch(32'h0000_1008);
        drain();

        test_name = "hit_b2b";
        fetch(32'h0000_1000);
        fetch(32'h0000_1004);
        fetch(32'h0000_1010);
        fetch(32'h0000_1018);
        fetch(32'h0000_1038);
        fetch(32'h0000_1008);
        drain();

        test_name = "plru_set";
        for (int i = 0; i < 11; i++) begin
            fetch((32'(plru_tags[i]) << 12) | (32'd5 << 6) | 32'h10);
        end
        drain();

        test_name = "misaligned";
        fetch(32'h0000_1002);
        fetch(32'h0000_2003);
        fetch(32'h0000_1004);
        drain();

        test_name = "random";
        for (int i = 0; i < num_random; i++) begin
            fetch(rand_pc[i]);
            if (rand_gap[i]) begin
                idle_cycle();
            end
        end
        drain();

        repeat (4) @(negedge clk);
        check("end stray bursts", 0, bus_addr_q.size());
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout: fetches still pending after %0d ns", timeout_ns);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/icache_props.sv
`timescale 1ns/1ps
`default_nettype none

module icache_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      r_req,
    input logic                      r_rdy,
    input logic                      data_valid,
    input logic                      cache_ready,
    input logic                      fill_finish,
    input icache_pkg::icache_state_e state
);

    // burst request held until the slave takes it
    assert property (@(posedge clk) disable iff (rst) r_req && !r_rdy |=> r_req)
        else $error("r_req dropped before r_rdy");

    // miss response is a single pulse
    assert property (@(posedge clk) disable iff (rst)
        data_valid && state == icache_pkg::st_resp |=> !data_valid)
        else $error("data_valid held after miss response");

    assert property (@(posedge clk) disable iff (rst)
        fill_finish |-> state == icache_pkg::st_refill)
        else $error("fill_finish outside refill");

    assert property (@(posedge clk) disable iff (rst)
        state == icache_pkg::st_idle |-> cache_ready)
        else $error("cache_ready low while idle");

endmodule

bind icache_fsm icache_props u_props (
    .clk         (clk),
    .rst         (rst),
    .r_req       (r_req),
    .r_rdy       (r_rdy),
    .data_valid  (data_valid),
    .cache_ready (cache_ready),
    .fill_finish (refill.fill_finish),
    .state       (state_q)
);

`default_nettype wire

//--- rtl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int cookie_width = icache_pkg::cookie_width_default
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  logic [31:0]             pc_in,
    input  logic [cookie_width-1:0] cookie_in,
    output logic                    data_valid,
    output logic [63:0]             r_data_cpu,
    output logic [31:0]             pc_out,
    output logic [cookie_width-1:0] cookie_out,
    output logic                    cache_ready,
    output logic                    r_req,
    output logic                    r_data_ready,
    output logic [31:0]             r_addr,
    input  logic                    r_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  logic [31:0]             r_data_axi,
    output logic [6:0]              exception
);

    logic [31:0]             pc_q;
    logic [cookie_width-1:0] cookie_q;
    logic                    rbuf_we;
    logic [3:0]              hit;
    logic                    cache_hit;
    logic [3:0]              valid_ways;
    logic [3:0]              way_replace;
    logic [3:0]              way_visit;
    logic [3:0]              tagv_we;
    logic [3:0]              mem_we;
    logic                    lru_en;
    logic                    rdata_sel;
    logic [63:0]             mem_dword;
    logic [63:0]             buf_dword;
    logic [icache_pkg::index_bits-1:0] rbuf_index;

    icache_refill_if refill ();

    // request buffer, holds pc and cookie until the response
    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            pc_q     <= pc_in;
            cookie_q <= cookie_in;
        end
    end

    assign pc_out     = pc_q;
    assign cookie_out = cookie_q;
    assign rbuf_index = pc_q[icache_pkg::offset_bits +: icache_pkg::index_bits];
    assign r_addr     = {pc_q[31:icache_pkg::offset_bits], {icache_pkg::offset_bits{1'b0}}};

    // misaligned fetch flags adef
    assign exception = (pc_q[1:0] != 2'b00) ? {1'b1, icache_pkg::ecode_adef} : 7'd0;

    assign refill.beat_data = r_data_axi;

    assign r_data_cpu = rdata_sel ? buf_dword : mem_dword;

    icache_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .cache_hit    (cache_hit),
        .hit          (hit),
        .way_replace  (way_replace),
        .r_rdy        (r_rdy),
        .refill       (refill),
        .rbuf_we      (rbuf_we),
        .tagv_we      (tagv_we),
        .mem_we       (mem_we),
        .way_visit    (way_visit),
        .lru_en       (lru_en),
        .rdata_sel    (rdata_sel),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .data_valid   (data_valid),
        .cache_ready  (cache_ready)
    );

    refill_counter u_refill_counter (
        .clk       (clk),
        .rst       (rst),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .refill    (refill)
    );

    refill_buf u_refill_buf (
        .clk    (clk),
        .offset (pc_q[5:3]),
        .dword  (buf_dword),
        .refill (refill)
    );

    tagv_mem u_tagv_mem (
        .clk        (clk),
        .rst        (rst),
        .r_index    (pc_in[icache_pkg::offset_bits +: icache_pkg::index_bits]),
        .w_addr     (pc_q),
        .we         (tagv_we),
        .lookup_tag (pc_q[31 -: icache_pkg::tag_bits]),
        .hit        (hit),
        .cache_hit  (cache_hit),
        .valid_ways (valid_ways)
    );

    data_mem u_data_mem (
        .clk     (clk),
        .r_index (pc_in[icache_pkg::offset_bits +: icache_pkg::index_bits]),
        .w_index (rbuf_index),
        .offset  (pc_q[5:3]),
        .line_in (refill.line),
        .we      (mem_we),
        .hit     (hit),
        .dword   (mem_dword)
    );

    lru_sel u_lru_sel (
        .clk         (clk),
        .rst         (rst),
        .index       (rbuf_index),
        .visit       (way_visit),
        .en          (lru_en),
        .valid_ways  (valid_ways),
        .way_replace (way_replace)
    );

endmodule

`default_nettype wire

//--- rtl/lru_sel.sv
`timescale 1ns/1ps
`default_nettype none

module lru_sel (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [icache_pkg::index_bits-1:0] index,
    input  logic [3:0]                        visit,
    input  logic                              en,
    input  logic [3:0]                        valid_ways,
    output logic [3:0]                        way_replace
);

    // bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
    logic [2:0] tree_q [icache_pkg::num_sets];
    logic [2:0] tree;

    assign tree = tree_q[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < icache_pkg::num_sets; s++) begin
                tree_q[s] <= 3'b000;
            end
        end else if (en) begin
            case (visit)
                4'b0001: tree_q[index] <= {tree[2], 1'b1, 1'b1};
                4'b0010: tree_q[index] <= {tree[2], 1'b0, 1'b1};
                4'b0100: tree_q[index] <= {1'b1, tree[1], 1'b0};
                4'b1000: tree_q[index] <= {1'b0, tree[1], 1'b0};
                default: tree_q[index] <= tree;  // no way touched
            endcase
        end
    end

    always_comb begin
        if (!valid_ways[0]) begin
            way_replace = 4'b0001;                      // fill empty ways first
        end else if (!valid_ways[1]) begin
            way_replace = 4'b0010;
        end else if (!valid_ways[2]) begin
            way_replace = 4'b0100;
        end else if (!valid_ways[3]) begin
            way_replace = 4'b1000;
        end else if (!tree[0]) begin
            way_replace = tree[1] ? 4'b0010 : 4'b0001;
        end else begin
            way_replace = tree[2] ? 4'b1000 : 4'b0100;
        end
    end

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                                  clk,
    input  logic [icache_pkg::index_bits-1:0]     r_index,
    input  logic [icache_pkg::index_bits-1:0]     w_index,
    input  logic [5:3]                            offset,
    input  logic [icache_pkg::line_words*32-1:0]  line_in,
    input  logic [3:0]                            we,
    input  logic [3:0]                            hit,
    output logic [63:0]                           dword
);

    localparam int line_bits = icache_pkg::line_words * 32;

    logic [line_bits-1:0] rd_line [icache_pkg::num_ways];
    logic [line_bits-1:0] hit_line;

    genvar w;
    generate
        for (w = 0; w < icache_pkg::num_ways; w++) begin : g_way
            logic [line_bits-1:0] line_ram [icache_pkg::num_sets];

            always_ff @(posedge clk) begin
                if (we[w]) begin
                    line_ram[w_index] <= line_in;
                end
                rd_line[w] <= line_ram[r_index];
            end
        end
    endgenerate

    // hit is one-hot, so an or of masked lines picks the way
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < icache_pkg::num_ways; i++) begin
            if (hit[i]) begin
                hit_line = hit_line | rd_line[i];
            end
        end
    end

    assign dword = hit_line[offset*64 +: 64];

endmodule

`default_nettype wire

//--- rtl/tagv_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tagv_mem (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [icache_pkg::index_bits-1:0] r_index,
    input  logic [31:0]                     w_addr,
    input  logic [3:0]                      we,
    input  logic [icache_pkg::tag_bits-1:0] lookup_tag,
    output logic [3:0]                      hit,
    output logic                            cache_hit,
    output logic [3:0]                      valid_ways
);

    logic [icache_pkg::index_bits-1:0] w_index;
    logic [icache_pkg::tag_bits-1:0]   w_tag;

    assign w_index = w_addr[icache_pkg::offset_bits +: icache_pkg::index_bits];
    assign w_tag   = w_addr[31 -: icache_pkg::tag_bits];

    genvar w;
    generate
        for (w = 0; w < icache_pkg::num_ways; w++) begin : g_way
            logic [icache_pkg::tag_bits-1:0] tag_ram [icache_pkg::num_sets];
            logic [icache_pkg::tag_bits-1:0] tag_rd;
            logic [icache_pkg::num_sets-1:0] valid_q;
            logic                            valid_rd;

            always_ff @(posedge clk) begin
                if (we[w]) begin
                    tag_ram[w_index] <= w_tag;
                end
                tag_rd <= tag_ram[r_index];          // sync read
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    valid_q  <= '0;
                    valid_rd <= 1'b0;
                end else begin
                    if (we[w]) begin
                        valid_q[w_index] <= 1'b1;
                    end
                    valid_rd <= valid_q[r_index];
                end
            end

            assign hit[w]        = valid_rd & (tag_rd == lookup_tag);
            assign valid_ways[w] = valid_q[w_index]; // set of the buffered pc
        end
    endgenerate

    assign cache_hit = |hit;

endmodule

`default_nettype wire

//--- rtl/refill_buf.sv
`timescale 1ns/1ps
`default_nettype none

module refill_buf (
    input  logic              clk,
    input  logic [5:3]        offset,
    output logic [63:0]       dword,
    icache_refill_if.buffer   refill
);

    logic [31:0] words_q [icache_pkg::line_words];

    always_ff @(posedge clk) begin
        if (refill.beat_valid) begin
            words_q[refill.beat_idx] <= refill.beat_data;
        end
    end

    // word 0 sits in the low bits of the line
    genvar i;
    generate
        for (i = 0; i < icache_pkg::line_words; i++) begin : g_pack
            assign refill.line[i*32 +: 32] = words_q[i];
        end
    endgenerate

    assign dword = refill.line[offset*64 +: 64];  // doubleword for miss response

endmodule

`default_nettype wire

//--- rtl/refill_counter.sv
`timescale 1ns/1ps
`default_nettype none

module refill_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              ret_valid,
    input  logic              ret_last,
    icache_refill_if.counter  refill
);

    logic [3:0] cnt_q;
    logic       finish_q;
    logic       beat;

    assign beat = refill.refill_active & ret_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q    <= 4'd0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= beat & (ret_last | (cnt_q == 4'd15));
            if (finish_q) begin
                cnt_q <= 4'd0;                           // ready for next line
            end else if (beat) begin
                cnt_q <= cnt_q + 4'd1;
            end
        end
    end

    assign refill.beat_valid  = beat;
    assign refill.beat_idx    = cnt_q;
    assign refill.fill_finish = finish_q;

endmodule

`default_nettype wire

//--- rtl/icache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic                cache_hit,
    input  logic [3:0]          hit,
    input  logic [3:0]          way_replace,
    input  logic                r_rdy,
    icache_refill_if.ctrl       refill,
    output logic                rbuf_we,
    output logic [3:0]          tagv_we,
    output logic [3:0]          mem_we,
    output logic [3:0]          way_visit,
    output logic                lru_en,
    output logic                rdata_sel,
    output logic                r_req,
    output logic                r_data_ready,
    output logic                data_valid,
    output logic                cache_ready
);

    icache_pkg::icache_state_e state_q, state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= icache_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        rbuf_we      = 1'b0;
        tagv_we      = 4'b0000;
        mem_we       = 4'b0000;
        way_visit    = 4'b0000;
        lru_en       = 1'b0;
        rdata_sel    = 1'b0;
        r_req        = 1'b0;
        r_data_ready = 1'b0;
        data_valid   = 1'b0;
        cache_ready  = 1'b0;
        case (state_q)
            icache_pkg::st_idle: begin
                cache_ready = 1'b1;
                rbuf_we     = valid;
                if (valid) begin
                    state_d = icache_pkg::st_lookup;
                end
            end
            icache_pkg::st_lookup: begin
                // a hit answers now and may take the next fetch
                cache_ready = cache_hit;
                data_valid  = cache_hit;
                lru_en      = cache_hit;
                way_visit   = hit;
                rbuf_we     = valid & cache_hit;
                if (!cache_hit) begin
                    state_d = icache_pkg::st_miss;
                end else if (!valid) begin
                    state_d = icache_pkg::st_idle;
                end
            end
            icache_pkg::st_miss: begin
                r_req = 1'b1;
                if (r_rdy) begin
                    state_d = icache_pkg::st_refill;
                end
            end
            icache_pkg::st_refill: begin
                r_data_ready = 1'b1;
                if (refill.fill_finish) begin
                    state_d = icache_pkg::st_write;
                end
            end
            icache_pkg::st_write: begin
                tagv_we   = way_replace;                 // set index held in rbuf
                mem_we    = way_replace;
                way_visit = way_replace;
                lru_en    = 1'b1;
                state_d   = icache_pkg::st_resp;
            end
            icache_pkg::st_resp: begin
                data_valid = 1'b1;
                rdata_sel  = 1'b1;                       // answer from line buffer
                state_d    = icache_pkg::st_idle;
            end
            default: begin
                state_d = icache_pkg::st_idle;
            end
        endcase
    end

    assign refill.refill_active = (state_q == icache_pkg::st_refill);

endmodule

`default_nettype wire

//--- rtl/icache_refill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface icache_refill_if;

    logic                                  beat_valid;    // accepted beat strobe
    logic [3:0]                            beat_idx;      // word slot in line
    logic [31:0]                           beat_data;
    logic                                  fill_finish;   // one cycle after last beat
    logic                                  refill_active; // fsm in st_refill
    logic [icache_pkg::line_words*32-1:0]  line;

    modport counter (
        input  refill_active,
        output beat_valid, beat_idx, fill_finish
    );

    modport buffer (
        input  beat_valid, beat_idx, beat_data,
        output line
    );

    modport ctrl (
        input  fill_finish,
        output refill_active
    );

endinterface

`default_nettype wire

//--- rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry, 4 ways x 64 sets x 64 bytes
    localparam int num_ways    = 4;
    localparam int num_sets    = 64;
    localparam int line_words  = 16;             // 32-bit words per line
    localparam int offset_bits = 6;              // byte offset in line
    localparam int index_bits  = 6;              // pc[11:6]
    localparam int tag_bits    = 20;             // pc[31:12]

    localparam int cookie_width_default = 32;

    // address-fetch exception code
    localparam logic [5:0] ecode_adef = 6'd8;

    // main control states
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_lookup = 3'd1,                        // tag compare, hit answered here
        st_miss   = 3'd2,                        // burst request pending
        st_refill = 3'd3,                        // collecting beats
        st_write  = 3'd4,                        // line and tag write
        st_resp   = 3'd5                         // miss response
    } icache_state_e;

endpackage

`default_nettype wire
